// File: bus_map_pkg.sv
package bus_map_pkg;

    // bus widths
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;
    typedef logic [2:0]  access_t;

    // load type codes
    localparam access_t acc_lb  = 3'b000;
    localparam access_t acc_lh  = 3'b001;
    localparam access_t acc_lw  = 3'b010;
    localparam access_t acc_ld  = 3'b011;
    localparam access_t acc_lbu = 3'b100;
    localparam access_t acc_lhu = 3'b101;
    localparam access_t acc_lwu = 3'b110;

    // store type codes
    localparam access_t acc_sb = 3'b000;
    localparam access_t acc_sh = 3'b001;
    localparam access_t acc_sw = 3'b010;
    localparam access_t acc_sd = 3'b011;

    // ram window, 2048 words of 32 bits
    localparam addr_t ram_base  = 32'h0000_1000;
    localparam addr_t ram_size  = 32'h0000_2000;
    localparam int    ram_words = 2048;
    localparam int    ram_idx_w = 11;

    // single registers
    localparam addr_t key_addr     = 32'h0000_8000;
    localparam addr_t uart_addr    = 32'h0000_8008;
    localparam addr_t sdc_addr_reg = 32'h0000_8010;
    localparam addr_t sdc_read     = 32'h0000_8018;
    localparam addr_t sdc_ready    = 32'h0000_8020;
    localparam addr_t sdc_avail    = 32'h0000_8028;

    // sector buffer window
    localparam addr_t sdc_buf_base = 32'h0000_9000;

endpackage

// File: periph_pkg.sv
package periph_pkg;

    // keyboard and interrupt
    typedef logic [7:0] char_t;
    typedef logic [3:0] irq_vec_t;

    localparam irq_vec_t key_irq_code = 4'd1;

    // sd sector buffer
    localparam int sector_bytes = 512;
    localparam int sector_aw    = 9;

    typedef logic [9:0]  byte_idx_t;
    typedef logic [31:0] sector_t;

    // ram access sequencing
    typedef enum logic [1:0] {
        idle,
        read_lo,
        read_hi,
        write_hi
    } ram_state_t;

endpackage

// File: bus_ram.sv
`timescale 1ns/1ps

module bus_ram import bus_map_pkg::*, periph_pkg::*; (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  addr_t   addr,
    input  data_t   wdata,
    input  logic    rd,
    input  logic    wr,
    input  access_t read_type,
    input  access_t write_type,
    output data_t   rdata,
    output logic    done
);

    word_t mem [0:ram_words-1];

    ram_state_t state;

    addr_t                offset;
    logic [ram_idx_w-1:0] idx;
    logic [ram_idx_w-1:0] next_idx;
    logic [ram_idx_w-1:0] raddr;
    logic [ram_idx_w-1:0] waddr;
    logic [3:0]           we;
    word_t                wword;
    word_t                hi_wdata;
    word_t                lo_q;
    word_t                hi_q;
    word_t                lane_word;
    logic [1:0]           lane_q;
    access_t              type_q;

    // word index inside the window
    assign offset = addr - ram_base;
    assign idx    = offset[ram_idx_w+1:2];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (rd) begin
                        state <= read_lo;
                    end else if (wr && write_type == acc_sd) begin
                        state <= write_hi;
                    end
                end
                read_lo:  state <= (type_q == acc_ld) ? read_hi : idle;
                read_hi:  state <= idle;
                write_hi: state <= idle;
                default:  state <= idle;
            endcase
        end
    end

    // byte enables for the single write port
    always_comb begin
        we    = 4'b0000;
        wword = wdata[31:0];
        waddr = idx;
        if (state == write_hi) begin
            we    = 4'b1111;
            wword = hi_wdata;
            waddr = next_idx;
        end else if (state == idle && wr) begin
            case (write_type)
                acc_sb: begin
                    we    = 4'b0001 << addr[1:0];
                    wword = {4{wdata[7:0]}};
                end
                acc_sh: begin
                    we    = addr[1] ? 4'b1100 : 4'b0011;
                    wword = {2{wdata[15:0]}};
                end
                acc_sw, acc_sd: we = 4'b1111;
                default: we = 4'b0000;
            endcase
        end
    end

    // second beat of a double read uses the next word
    assign raddr = (state == read_lo) ? next_idx : idx;

    always_ff @(posedge CLOCK_50) begin
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                mem[waddr][8*b +: 8] <= wword[8*b +: 8];
            end
        end
        if (state == idle && (rd || wr)) begin
            next_idx <= idx + 1'b1;
            hi_wdata <= wdata[63:32];
        end
        if (state == idle && rd) begin
            lo_q   <= mem[raddr];
            lane_q <= addr[1:0];
            type_q <= read_type;
        end
        if (state == read_lo) begin
            hi_q <= mem[raddr];
        end
    end

    assign lane_word = lo_q >> {lane_q, 3'b000};

    // lane select and extension
    always_comb begin
        case (type_q)
            acc_lb:  rdata = {{56{lane_word[7]}}, lane_word[7:0]};
            acc_lh:  rdata = {{48{lane_word[15]}}, lane_word[15:0]};
            acc_lw:  rdata = {{32{lo_q[31]}}, lo_q};
            acc_ld:  rdata = {hi_q, lo_q};
            acc_lbu: rdata = {56'd0, lane_word[7:0]};
            acc_lhu: rdata = {48'd0, lane_word[15:0]};
            acc_lwu: rdata = {32'd0, lo_q};
            default: rdata = '0;
        endcase
    end

    assign done = (state == read_lo && type_q != acc_ld) || state == read_hi;

endmodule

// File: bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric import bus_map_pkg::*, periph_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  addr_t     bus_address,
    input  data_t     bus_write_data,
    input  logic      bus_write_enable,
    input  logic      bus_read_enable,
    input  data_t     ram_rdata,
    input  logic      ram_done,
    input  char_t     key_char,
    input  logic      sd_ready_flag,
    input  char_t     buf_byte,
    input  logic      buf_avail,
    output data_t     bus_read_data,
    output logic      bus_read_done,
    output logic      ram_rd,
    output logic      ram_wr,
    output byte_idx_t buf_index,
    output logic      sdc_addr_wr,
    output logic      sdc_rd_wr,
    output char_t     uart_data,
    output logic      uart_write
);

    logic  ram_sel;
    logic  key_sel;
    logic  uart_sel;
    logic  sdc_addr_sel;
    logic  sdc_read_sel;
    logic  sdc_ready_sel;
    logic  sdc_avail_sel;
    logic  buf_sel;
    logic  uart_strobe;
    logic  uart_strobe_q;
    logic  rd_pend;
    logic  rd_land;
    addr_t buf_offset;
    data_t periph_rdata;

    // address map
    assign ram_sel       = bus_address >= ram_base && bus_address < ram_base + ram_size;
    assign key_sel       = bus_address == key_addr;
    assign uart_sel      = bus_address == uart_addr;
    assign sdc_addr_sel  = bus_address == sdc_addr_reg;
    assign sdc_read_sel  = bus_address == sdc_read;
    assign sdc_ready_sel = bus_address == sdc_ready;
    assign sdc_avail_sel = bus_address == sdc_avail;
    assign buf_sel       = bus_address >= sdc_buf_base &&
                           bus_address < sdc_buf_base + sector_bytes;

    assign ram_rd      = bus_read_enable && ram_sel;
    assign ram_wr      = bus_write_enable && ram_sel;
    assign sdc_addr_wr = bus_write_enable && sdc_addr_sel;
    assign sdc_rd_wr   = bus_write_enable && sdc_read_sel;
    assign uart_strobe = bus_write_enable && uart_sel;

    assign buf_offset = bus_address - sdc_buf_base;
    assign buf_index  = byte_idx_t'(buf_offset);

    // unmapped reads fall through to zero
    always_comb begin
        if (key_sel) begin
            periph_rdata = {56'd0, key_char};
        end else if (sdc_ready_sel) begin
            periph_rdata = {63'd0, sd_ready_flag};
        end else if (sdc_avail_sel) begin
            periph_rdata = {63'd0, buf_avail};
        end else if (buf_sel) begin
            periph_rdata = {56'd0, buf_byte};
        end else begin
            periph_rdata = '0;
        end
    end

    // ram waits for its done, everything else lands one cycle later
    assign rd_land = rd_pend && !bus_read_enable && (!ram_sel || ram_done);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
            rd_pend       <= 1'b0;
            uart_strobe_q <= 1'b0;
            uart_write    <= 1'b0;
        end else begin
            uart_strobe_q <= uart_strobe;
            uart_write    <= uart_strobe && !uart_strobe_q;
            if (bus_read_enable) begin
                rd_pend       <= 1'b1;
                bus_read_done <= 1'b0;
            end else if (rd_land) begin
                rd_pend       <= 1'b0;
                bus_read_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_land) begin
            bus_read_data <= ram_sel ? ram_rdata : periph_rdata;
        end
        if (uart_strobe && !uart_strobe_q) begin
            uart_data <= bus_write_data[7:0];
        end
    end

endmodule

// File: key_irq.sv
`timescale 1ns/1ps

module key_irq import periph_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     key_pressed,
    input  char_t    ascii,
    input  logic     interrupt_ack,
    output char_t    key_char,
    output irq_vec_t interrupt_vector
);

    logic key_q;
    logic key_edge;

    assign key_edge = key_pressed && !key_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_q            <= 1'b0;
            key_char         <= '0;
            interrupt_vector <= '0;
        end else begin
            key_q <= key_pressed;
            if (key_edge) begin
                key_char <= ascii;
            end
            // a fresh press wins over an ack in the same cycle
            if (key_edge && ascii != '0) begin
                interrupt_vector <= key_irq_code;
            end else if (interrupt_vector != '0 && interrupt_ack) begin
                interrupt_vector <= '0;
            end
        end
    end

endmodule

// File: sd_regs.sv
`timescale 1ns/1ps

module sd_regs import periph_pkg::*; (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  logic    sdc_addr_wr,
    input  logic    sdc_rd_wr,
    input  sector_t wdata,
    input  logic    sd_ready,
    output sector_t sd_addr,
    output logic    sd_rd_start,
    output logic    sd_ready_flag
);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr       <= '0;
            sd_rd_start   <= 1'b0;
            sd_ready_flag <= 1'b0;
        end else begin
            // sector address seen by the controller
            if (sdc_addr_wr) begin
                sd_addr <= wdata;
            end
            // one pulse per write, the write strobe is single cycle
            sd_rd_start   <= sdc_rd_wr;
            sd_ready_flag <= sd_ready;
        end
    end

endmodule

// File: sector_buffer.sv
`timescale 1ns/1ps

module sector_buffer import periph_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  char_t     sd_dout,
    input  logic      sd_byte_available,
    input  logic      sd_rd_start,
    input  byte_idx_t buf_index,
    output char_t     buf_byte,
    output logic      buf_avail
);

    char_t mem [0:sector_bytes-1];

    byte_idx_t fill_idx;
    logic      avail_q;
    logic      byte_edge;
    logic      last_byte;

    assign byte_edge = sd_byte_available && !avail_q;
    assign last_byte = fill_idx == byte_idx_t'(sector_bytes - 1);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            avail_q   <= 1'b0;
            fill_idx  <= '0;
            buf_avail <= 1'b0;
        end else begin
            avail_q <= sd_byte_available;
            if (sd_rd_start) begin
                // new sector request restarts the fill
                fill_idx  <= '0;
                buf_avail <= 1'b0;
            end else if (byte_edge) begin
                if (last_byte) begin
                    fill_idx  <= '0;
                    buf_avail <= 1'b1;
                end else begin
                    fill_idx <= fill_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_edge && !sd_rd_start) begin
            mem[fill_idx[sector_aw-1:0]] <= sd_dout;
        end
    end

    // fabric registers this on its read path
    assign buf_byte = mem[buf_index[sector_aw-1:0]];

endmodule

// File: cpu_io_top.sv
`timescale 1ns/1ps

module cpu_io_top import bus_map_pkg::*, periph_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  addr_t    bus_address,
    input  data_t    bus_write_data,
    input  logic     bus_write_enable,
    input  logic     bus_read_enable,
    input  access_t  bus_read_type,
    input  access_t  bus_write_type,
    output data_t    bus_read_data,
    output logic     bus_read_done,
    output irq_vec_t interrupt_vector,
    input  logic     interrupt_ack,
    input  logic     key_pressed,
    input  char_t    ascii,
    input  char_t    sd_dout,
    input  logic     sd_byte_available,
    input  logic     sd_ready,
    output sector_t  sd_addr,
    output logic     sd_rd_start,
    output char_t    uart_data,
    output logic     uart_write
);

    data_t     ram_rdata;
    logic      ram_done;
    logic      ram_rd;
    logic      ram_wr;
    char_t     key_char;
    logic      sd_ready_flag;
    char_t     buf_byte;
    logic      buf_avail;
    byte_idx_t buf_index;
    logic      sdc_addr_wr;
    logic      sdc_rd_wr;

    bus_fabric bus_fabric_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .ram_rdata        (ram_rdata),
        .ram_done         (ram_done),
        .key_char         (key_char),
        .sd_ready_flag    (sd_ready_flag),
        .buf_byte         (buf_byte),
        .buf_avail        (buf_avail),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .ram_rd           (ram_rd),
        .ram_wr           (ram_wr),
        .buf_index        (buf_index),
        .sdc_addr_wr      (sdc_addr_wr),
        .sdc_rd_wr        (sdc_rd_wr),
        .uart_data        (uart_data),
        .uart_write       (uart_write)
    );

    bus_ram bus_ram_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .addr       (bus_address),
        .wdata      (bus_write_data),
        .rd         (ram_rd),
        .wr         (ram_wr),
        .read_type  (bus_read_type),
        .write_type (bus_write_type),
        .rdata      (ram_rdata),
        .done       (ram_done)
    );

    key_irq key_irq_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_pressed      (key_pressed),
        .ascii            (ascii),
        .interrupt_ack    (interrupt_ack),
        .key_char         (key_char),
        .interrupt_vector (interrupt_vector)
    );

    // sector address is the low word of the store data
    sd_regs sd_regs_inst (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .sdc_addr_wr   (sdc_addr_wr),
        .sdc_rd_wr     (sdc_rd_wr),
        .wdata         (bus_write_data[31:0]),
        .sd_ready      (sd_ready),
        .sd_addr       (sd_addr),
        .sd_rd_start   (sd_rd_start),
        .sd_ready_flag (sd_ready_flag)
    );

    sector_buffer sector_buffer_inst (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_rd_start       (sd_rd_start),
        .buf_index         (buf_index),
        .buf_byte          (buf_byte),
        .buf_avail         (buf_avail)
    );

endmodule

// File: tb_cpu_io.sv
`timescale 1ns/1ps

module tb_cpu_io import bus_map_pkg::*, periph_pkg::*; ();

    // table operations
    localparam int op_store = 0;
    localparam int op_load  = 1;
    localparam int op_key   = 2;
    localparam int op_ack   = 3;
    localparam int op_fill  = 4;
    localparam int op_uart  = 5;
    localparam int op_ready = 6;

    // cycles a load may take before it counts as a hang
    localparam int read_cap = 20;

    logic     CLOCK_50;
    logic     KEY0;
    addr_t    bus_address;
    data_t    bus_write_data;
    logic     bus_write_enable;
    logic     bus_read_enable;
    access_t  bus_read_type;
    access_t  bus_write_type;
    data_t    bus_read_data;
    logic     bus_read_done;
    irq_vec_t interrupt_vector;
    logic     interrupt_ack;
    logic     key_pressed;
    char_t    ascii;
    char_t    sd_dout;
    logic     sd_byte_available;
    logic     sd_ready;
    sector_t  sd_addr;
    logic     sd_rd_start;
    char_t    uart_data;
    logic     uart_write;

    string   t_name [$];
    int      t_op   [$];
    addr_t   t_addr [$];
    access_t t_type [$];
    data_t   t_data [$];
    data_t   t_exp  [$];

    char_t  sd_bytes [0:sector_bytes-1];
    integer seed;
    integer rnd;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     uart_pulses;
    int     start_pulses;
    logic   table_ready;

    cpu_io_top cpu_io_top_inst (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_type     (bus_read_type),
        .bus_write_type    (bus_write_type),
        .bus_read_data     (bus_read_data),
        .bus_read_done     (bus_read_done),
        .interrupt_vector  (interrupt_vector),
        .interrupt_ack     (interrupt_ack),
        .key_pressed       (key_pressed),
        .ascii             (ascii),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_ready          (sd_ready),
        .sd_addr           (sd_addr),
        .sd_rd_start       (sd_rd_start),
        .uart_data         (uart_data),
        .uart_write        (uart_write)
    );

    always #10 CLOCK_50 = ~CLOCK_50;

    // pulse counters sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (uart_write) begin
            uart_pulses++;
        end
        if (sd_rd_start) begin
            start_pulses++;
        end
    end

    initial begin
        wait (table_ready);
        repeat (t_name.size() * 600 + 1000) @(posedge CLOCK_50);
        $display("watchdog expired before the test table finished");
        $display("Some tests failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge CLOCK_50);
        #2;
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic add_test(input string name, input int op, input addr_t addr,
                            input access_t ty, input data_t data, input data_t expected);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_type.push_back(ty);
        t_data.push_back(data);
        t_exp.push_back(expected);
    endtask

    task automatic bus_store(input addr_t addr, input access_t ty, input data_t data);
        next_cycle();
        bus_address      = addr;
        bus_write_type   = ty;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        next_cycle();
        bus_write_enable = 1'b0;
        // idle cycle so an sd store can finish its upper word
        next_cycle();
    endtask

    task automatic bus_load(input string name, input addr_t addr, input access_t ty,
                            output data_t value);
        int waited;
        waited = 0;
        next_cycle();
        bus_address     = addr;
        bus_read_type   = ty;
        bus_read_enable = 1'b1;
        next_cycle();
        bus_read_enable = 1'b0;
        while (!bus_read_done && waited < read_cap) begin
            next_cycle();
            waited++;
        end
        if (!bus_read_done) begin
            $display("%s: bus_read_done never rose, the read hangs", name);
            errors++;
        end
        value = bus_read_data;
    endtask

    task automatic press_key(input char_t code, output irq_vec_t vec_seen);
        next_cycle();
        ascii       = code;
        key_pressed = 1'b1;
        next_cycle();
        vec_seen    = interrupt_vector;
        key_pressed = 1'b0;
        next_cycle();
    endtask

    task automatic ack_interrupt();
        next_cycle();
        interrupt_ack = 1'b1;
        next_cycle();
        interrupt_ack = 1'b0;
    endtask

    // one byte every two cycles
    task automatic fill_sector();
        for (int n = 0; n < sector_bytes; n++) begin
            next_cycle();
            sd_dout           = sd_bytes[n];
            sd_byte_available = 1'b1;
            next_cycle();
            sd_byte_available = 1'b0;
        end
        next_cycle();
    endtask

    initial begin
        int       errs_before;
        int       uart_before;
        int       start_before;
        data_t    value;
        irq_vec_t vec_seen;

        CLOCK_50          = 1'b0;
        KEY0              = 1'b0;
        bus_address       = '0;
        bus_write_data    = '0;
        bus_write_enable  = 1'b0;
        bus_read_enable   = 1'b0;
        bus_read_type     = acc_ld;
        bus_write_type    = acc_sd;
        interrupt_ack     = 1'b0;
        key_pressed       = 1'b0;
        ascii             = '0;
        sd_dout           = '0;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        uart_pulses       = 0;
        start_pulses      = 0;
        table_ready       = 1'b0;

        // sector contents kept as the expected buffer data
        seed = 32'hd3a2;
        for (int n = 0; n < sector_bytes; n++) begin
            rnd         = $random(seed);
            sd_bytes[n] = rnd[7:0];
        end

        add_test("sd_store", op_store, 32'h1000, acc_sd, 64'h8877_6655_4433_2211, 64'h0);
        add_test("ld_full", op_load, 32'h1000, acc_ld, 64'h0, 64'h8877_6655_4433_2211);
        add_test("sw_neg", op_store, 32'h1010, acc_sw, 64'h0000_0000_8000_1234, 64'h0);
        add_test("lw_sign", op_load, 32'h1010, acc_lw, 64'h0, 64'hFFFF_FFFF_8000_1234);
        add_test("lwu_zero", op_load, 32'h1010, acc_lwu, 64'h0, 64'h0000_0000_8000_1234);
        add_test("sw_bytes", op_store, 32'h1020, acc_sw, 64'h0000_0000_A1B2_C3D4, 64'h0);
        add_test("sb_lane0", op_store, 32'h1020, acc_sb, 64'h1111_2222_3333_4485, 64'h0);
        add_test("lb_lane0", op_load, 32'h1020, acc_lb, 64'h0, 64'hFFFF_FFFF_FFFF_FF85);
        add_test("lbu_lane1_kept", op_load, 32'h1021, acc_lbu, 64'h0, 64'hC3);
        add_test("sb_lane1", op_store, 32'h1021, acc_sb, 64'h16, 64'h0);
        add_test("lb_lane1", op_load, 32'h1021, acc_lb, 64'h0, 64'h16);
        add_test("sb_lane2", op_store, 32'h1022, acc_sb, 64'hF0, 64'h0);
        add_test("lbu_lane2", op_load, 32'h1022, acc_lbu, 64'h0, 64'hF0);
        add_test("lb_lane3_kept", op_load, 32'h1023, acc_lb, 64'h0, 64'hFFFF_FFFF_FFFF_FFA1);
        add_test("sb_lane3", op_store, 32'h1023, acc_sb, 64'h7E, 64'h0);
        add_test("lb_lane3", op_load, 32'h1023, acc_lb, 64'h0, 64'h7E);
        add_test("lw_lanes", op_load, 32'h1020, acc_lw, 64'h0, 64'h0000_0000_7EF0_1685);
        add_test("sw_halves", op_store, 32'h1030, acc_sw, 64'h0000_0000_1122_3344, 64'h0);
        add_test("sh_low", op_store, 32'h1030, acc_sh, 64'h5555_6666_7777_8001, 64'h0);
        add_test("lh_low", op_load, 32'h1030, acc_lh, 64'h0, 64'hFFFF_FFFF_FFFF_8001);
        add_test("lhu_high_kept", op_load, 32'h1032, acc_lhu, 64'h0, 64'h1122);
        add_test("sh_high", op_store, 32'h1032, acc_sh, 64'hCAFE, 64'h0);
        add_test("lhu_high", op_load, 32'h1032, acc_lhu, 64'h0, 64'hCAFE);
        add_test("lh_high", op_load, 32'h1032, acc_lh, 64'h0, 64'hFFFF_FFFF_FFFF_CAFE);
        add_test("lhu_low_kept", op_load, 32'h1030, acc_lhu, 64'h0, 64'h8001);
        add_test("key_press", op_key, 32'h0, acc_lb, 64'h41, 64'h1);
        add_test("key_load", op_load, key_addr, acc_ld, 64'h0, 64'h41);
        add_test("unmapped", op_load, 32'h4000, acc_ld, 64'h0, 64'h0);
        add_test("key_ack", op_ack, 32'h0, acc_lb, 64'h0, 64'h0);
        add_test("key_zero", op_key, 32'h0, acc_lb, 64'h0, 64'h0);
        add_test("uart_write", op_uart, uart_addr, acc_sw, 64'hDEAD_BEEF_0000_A55A, 64'h5A);
        add_test("sd_addr", op_store, sdc_addr_reg, acc_sw, 64'h0012_3400, 64'h0012_3400);
        add_test("sd_start", op_store, sdc_read, acc_sw, 64'h1, 64'h1);
        add_test("sd_fill", op_fill, 32'h0, acc_lb, 64'h0, 64'h0);
        add_test("sd_avail", op_load, sdc_avail, acc_ld, 64'h0, 64'h1);
        add_test("buf_0", op_load, sdc_buf_base, acc_lbu, 64'h0, {56'd0, sd_bytes[0]});
        add_test("buf_1", op_load, sdc_buf_base + 32'd1, acc_lbu, 64'h0, {56'd0, sd_bytes[1]});
        add_test("buf_255", op_load, sdc_buf_base + 32'd255, acc_lbu, 64'h0,
                 {56'd0, sd_bytes[255]});
        add_test("buf_511", op_load, sdc_buf_base + 32'd511, acc_lbu, 64'h0,
                 {56'd0, sd_bytes[511]});
        add_test("sd_ready_hi", op_ready, sdc_ready, acc_ld, 64'h1, 64'h1);
        add_test("sd_ready_lo", op_ready, sdc_ready, acc_ld, 64'h0, 64'h0);
        table_ready = 1'b1;

        repeat (2) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;

        // state straight out of reset
        errs_before = errors;
        check_value("reset_done", 64'h1, {63'd0, bus_read_done});
        check_value("reset_irq", 64'h0, {60'd0, interrupt_vector});
        check_value("reset_uart", 64'h0, {63'd0, uart_write});
        check_value("reset_start", 64'h0, {63'd0, sd_rd_start});
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test reset_state: %s", (errors == errs_before) ? "pass" : "fail");

        for (int i = 0; i < t_name.size(); i++) begin
            errs_before  = errors;
            uart_before  = uart_pulses;
            start_before = start_pulses;
            case (t_op[i])
                op_store: begin
                    bus_store(t_addr[i], t_type[i], t_data[i]);
                    if (t_addr[i] == sdc_addr_reg) begin
                        check_value(t_name[i], t_exp[i], {32'd0, sd_addr});
                    end else if (t_addr[i] == sdc_read) begin
                        repeat (2) next_cycle();
                        check_value(t_name[i], t_exp[i], 64'(start_pulses - start_before));
                    end
                end
                op_load: begin
                    bus_load(t_name[i], t_addr[i], t_type[i], value);
                    check_value(t_name[i], t_exp[i], value);
                end
                op_key: begin
                    press_key(t_data[i][7:0], vec_seen);
                    check_value(t_name[i], t_exp[i], {60'd0, vec_seen});
                end
                op_ack: begin
                    ack_interrupt();
                    check_value(t_name[i], t_exp[i], {60'd0, interrupt_vector});
                end
                op_fill: begin
                    fill_sector();
                end
                op_uart: begin
                    bus_store(t_addr[i], t_type[i], t_data[i]);
                    repeat (2) next_cycle();
                    check_value(t_name[i], 64'h1, 64'(uart_pulses - uart_before));
                    check_value(t_name[i], t_exp[i], {56'd0, uart_data});
                end
                op_ready: begin
                    sd_ready = t_data[i][0];
                    repeat (2) next_cycle();
                    bus_load(t_name[i], t_addr[i], t_type[i], value);
                    check_value(t_name[i], t_exp[i], value);
                end
                default: begin
                    $display("%s: unknown operation in the test table", t_name[i]);
                    errors++;
                end
            endcase
            tests_run++;
            if (errors != errs_before) begin
                tests_failed++;
            end
            $display("test %s: %s", t_name[i], (errors == errs_before) ? "pass" : "fail");
        end

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
bus_map_pkg.sv
periph_pkg.sv
bus_ram.sv
bus_fabric.sv
key_irq.sv
sd_regs.sv
sector_buffer.sv
cpu_io_top.sv
tb_cpu_io.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module tb_cpu_io -o tb_cpu_io_sim
./obj_dir/tb_cpu_io_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
